// ==== design/motor_pool_pkg.sv ====
package motor_pool_pkg;

    ////////////////////////////////////////
    // pool sizing
    ////////////////////////////////////////

    // neurons in the motor pool
    localparam int POOL_SIZE    = 4;
    // ticks per counting window
    localparam int WINDOW_TICKS = 16;
    localparam int TICK_CNT_W   = $clog2(WINDOW_TICKS);

    ////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////

    // apb data word and byte address
    typedef logic [31:0] data_t;
    typedef logic [7:0]  addr_t;
    // synaptic current and membrane potential
    typedef logic [23:0] current_t;
    typedef logic [23:0] potential_t;
    // spike total of one window
    typedef logic [15:0] count_t;
    // tick period, clock cycles minus one
    typedef logic [15:0] period_t;
    // tick position inside a window
    typedef logic [TICK_CNT_W-1:0] tick_cnt_t;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////

    localparam addr_t ADDR_CTRL   = 8'h00;
    localparam addr_t ADDR_PERIOD = 8'h04;
    localparam addr_t ADDR_GAIN   = 8'h08;
    localparam addr_t ADDR_THRESH = 8'h0C;
    // read only, latched window total
    localparam addr_t ADDR_COUNT  = 8'h10;

    // reset defaults
    localparam period_t    PERIOD_RESET = 16'd9;
    localparam current_t   GAIN_RESET   = 24'd0;
    localparam potential_t THRESH_RESET = 24'd1000;

    // parameters seen by the drive and the neurons
    typedef struct packed {
        logic       run;
        period_t    period;
        current_t   gain;
        potential_t threshold;
    } param_regs_t;

endpackage

// ==== design/apb_param_bank.sv ====
`timescale 1ns/1ps

module apb_param_bank (
    input  logic                        ep50trig,
    input  logic                        reset_sim,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  motor_pool_pkg::addr_t       i_paddr,
    input  motor_pool_pkg::data_t       i_pwdata,
    output motor_pool_pkg::data_t       o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    input  motor_pool_pkg::count_t      i_window_count,
    output motor_pool_pkg::param_regs_t o_regs
);
    import motor_pool_pkg::*;

    // access phase of an apb transfer
    logic  access;
    // address decodes to a register
    logic  addr_hit;
    // unmapped address or write to the count
    logic  bad_access;
    logic  wr_en;
    data_t rd_data;

    assign access = i_psel & i_penable;

    ////////////////////////////////////////
    // address decode and readback mux
    ////////////////////////////////////////

    always_comb
    begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (i_paddr)
            ADDR_CTRL:   rd_data = data_t'(o_regs.run);
            ADDR_PERIOD: rd_data = data_t'(o_regs.period);
            ADDR_GAIN:   rd_data = data_t'(o_regs.gain);
            ADDR_THRESH: rd_data = data_t'(o_regs.threshold);
            ADDR_COUNT:  rd_data = data_t'(i_window_count);
            default:     addr_hit = 1'b0;
        endcase
    end

    // count register takes no writes
    assign bad_access = ~addr_hit | (i_pwrite & (i_paddr == ADDR_COUNT));
    assign wr_en      = access & i_pwrite & ~bad_access;

    // zero wait states, data valid in the access cycle
    assign o_pready  = access;
    assign o_pslverr = access & bad_access;
    assign o_prdata  = (access && !i_pwrite) ? rd_data : '0;

    ////////////////////////////////////////
    // register writes
    ////////////////////////////////////////

    // write lands on the edge closing the access phase
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_regs.run       <= 1'b0;
            o_regs.period    <= PERIOD_RESET;
            o_regs.gain      <= GAIN_RESET;
            o_regs.threshold <= THRESH_RESET;
        end
        else if (wr_en)
        begin
            case (i_paddr)
                ADDR_CTRL:   o_regs.run       <= i_pwdata[0];
                ADDR_PERIOD: o_regs.period    <= period_t'(i_pwdata);
                ADDR_GAIN:   o_regs.gain      <= current_t'(i_pwdata);
                ADDR_THRESH: o_regs.threshold <= potential_t'(i_pwdata);
                default:     o_regs.run       <= o_regs.run;
            endcase
        end
    end

    ////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////

    // setup is always followed by a ready access phase
    a_ready_after_setup: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        (i_psel && !i_penable) |=> (i_penable && o_pready)
    );

    // error only in an access phase that follows its setup
    a_slverr_in_access: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        o_pslverr |-> (access && $past(i_psel && !i_penable))
    );

endmodule

// ==== design/afferent_drive.sv ====
`timescale 1ns/1ps

module afferent_drive (
    input  logic                                                 ep50trig,
    input  logic                                                 reset_sim,
    input  motor_pool_pkg::param_regs_t                          i_regs,
    output logic                                                 o_tick,
    output logic                                                 o_run_start,
    output motor_pool_pkg::current_t [motor_pool_pkg::POOL_SIZE-1:0] o_current
);
    import motor_pool_pkg::*;

    // cycle divider toward the next tick
    period_t div_cnt;
    // run delayed one cycle, for the edge detect
    logic    run_q;
    logic    run_rise;
    logic    div_wrap;

    ////////////////////////////////////////
    // run edge and tick divider
    ////////////////////////////////////////

    assign run_rise    = i_regs.run & ~run_q;
    assign o_run_start = run_rise;
    // period shrunk below the count also wraps
    assign div_wrap    = (div_cnt >= i_regs.period);

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            run_q   <= 1'b0;
            div_cnt <= '0;
        end
        else
        begin
            run_q <= i_regs.run;
            // restart the divider on a new run
            if (!i_regs.run || run_rise || div_wrap)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + period_t'(1);
        end
    end

    // one cycle tick every period+1 cycles
    assign o_tick = i_regs.run & run_q & div_wrap;

    ////////////////////////////////////////
    // per neuron synaptic current
    ////////////////////////////////////////

    // neuron k sees gain * (k+1)
    always_comb
    begin
        for (int k = 0; k < POOL_SIZE; k++)
        begin
            o_current[k] = current_t'(i_regs.gain * current_t'(k + 1));
        end
    end

    // tick only once run has been on for a cycle
    a_tick_needs_run: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        $rose(o_tick) |-> (i_regs.run && $past(i_regs.run))
    );

endmodule

// ==== design/lif_neuron.sv ====
`timescale 1ns/1ps

module lif_neuron (
    input  logic                          ep50trig,
    input  logic                          reset_sim,
    input  logic                          i_tick,
    input  logic                          i_clear,
    input  motor_pool_pkg::current_t      i_current,
    input  motor_pool_pkg::potential_t    i_threshold,
    output logic                          o_spike
);
    import motor_pool_pkg::*;

    // membrane potential, no leak
    potential_t pot;
    // one extra bit so the sum never wraps
    logic [$bits(potential_t):0] acc;
    logic fire;

    always_comb
    begin
        acc  = {1'b0, pot} + {1'b0, i_current};
        fire = (acc >= {1'b0, i_threshold});
    end

    ////////////////////////////////////////
    // integrate and fire
    ////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            pot     <= '0;
            o_spike <= 1'b0;
        end
        else if (i_clear)
        begin
            pot     <= '0;
            o_spike <= 1'b0;
        end
        else if (i_tick)
        begin
            // keep the remainder above threshold
            o_spike <= fire;
            pot     <= fire ? potential_t'(acc - {1'b0, i_threshold}) : potential_t'(acc);
        end
        else
            o_spike <= 1'b0;
    end

    // outside a spike cycle the potential sits under threshold
    a_below_threshold: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        !o_spike |-> (pot < i_threshold)
    );

endmodule

// ==== design/spike_window_counter.sv ====
`timescale 1ns/1ps

module spike_window_counter (
    input  logic                                 ep50trig,
    input  logic                                 reset_sim,
    input  logic                                 i_tick,
    input  logic                                 i_clear,
    input  logic [motor_pool_pkg::POOL_SIZE-1:0] i_spikes,
    output motor_pool_pkg::count_t               o_window_count,
    output logic                                 o_window_done
);
    import motor_pool_pkg::*;

    // ticks seen in the current window
    tick_cnt_t tick_cnt;
    // last tick of the window was one cycle ago
    logic      window_end;
    // running total of the window
    count_t    sum;
    // spikes arriving this cycle
    count_t    pop;

    always_comb
    begin
        pop = '0;
        for (int k = 0; k < POOL_SIZE; k++)
        begin
            pop = pop + count_t'(i_spikes[k]);
        end
    end

    ////////////////////////////////////////
    // window sum and latch
    ////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            tick_cnt       <= '0;
            window_end     <= 1'b0;
            sum            <= '0;
            o_window_count <= '0;
            o_window_done  <= 1'b0;
        end
        else
        begin
            o_window_done <= 1'b0;
            if (i_clear)
            begin
                // fresh run, drop the partial window
                tick_cnt   <= '0;
                window_end <= 1'b0;
                sum        <= '0;
            end
            else
            begin
                window_end <= 1'b0;
                if (i_tick)
                begin
                    if (tick_cnt == tick_cnt_t'(WINDOW_TICKS - 1))
                    begin
                        tick_cnt   <= '0;
                        window_end <= 1'b1;
                    end
                    else
                        tick_cnt <= tick_cnt + tick_cnt_t'(1);
                end
                // spikes of the last tick land now
                if (window_end)
                begin
                    o_window_count <= sum + pop;
                    sum            <= '0;
                    o_window_done  <= 1'b1;
                end
                else
                    sum <= sum + pop;
            end
        end
    end

    // spikes land only in the cycle right after a tick
    a_spikes_follow_tick: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        (i_spikes != '0) |-> $past(i_tick)
    );

endmodule

// ==== design/motor_pool_top.sv ====
`timescale 1ns/1ps

module motor_pool_top (
    input  logic                                 ep50trig,
    input  logic                                 reset_sim,
    input  logic                                 i_psel,
    input  logic                                 i_penable,
    input  logic                                 i_pwrite,
    input  motor_pool_pkg::addr_t                i_paddr,
    input  motor_pool_pkg::data_t                i_pwdata,
    output motor_pool_pkg::data_t                o_prdata,
    output logic                                 o_pready,
    output logic                                 o_pslverr,
    output logic [motor_pool_pkg::POOL_SIZE-1:0] o_spikes,
    output logic                                 o_window_done
);
    import motor_pool_pkg::*;

    ////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////

    param_regs_t               regs;
    logic                      tick;
    logic                      run_start;
    current_t [POOL_SIZE-1:0]  current;
    count_t                    window_count;

    // host registers
    apb_param_bank apb_param_bank_inst (
        .ep50trig       (ep50trig),
        .reset_sim      (reset_sim),
        .i_psel         (i_psel),
        .i_penable      (i_penable),
        .i_pwrite       (i_pwrite),
        .i_paddr        (i_paddr),
        .i_pwdata       (i_pwdata),
        .o_prdata       (o_prdata),
        .o_pready       (o_pready),
        .o_pslverr      (o_pslverr),
        .i_window_count (window_count),
        .o_regs         (regs)
    );

    // ticks and synaptic drive
    afferent_drive afferent_drive_inst (
        .ep50trig    (ep50trig),
        .reset_sim   (reset_sim),
        .i_regs      (regs),
        .o_tick      (tick),
        .o_run_start (run_start),
        .o_current   (current)
    );

    // the motoneuron pool
    generate
        for (genvar k = 0; k < POOL_SIZE; k++)
        begin : g_neuron
            lif_neuron lif_neuron_inst (
                .ep50trig    (ep50trig),
                .reset_sim   (reset_sim),
                .i_tick      (tick),
                .i_clear     (run_start),
                .i_current   (current[k]),
                .i_threshold (regs.threshold),
                .o_spike     (o_spikes[k])
            );
        end
    endgenerate

    // pool total per window
    spike_window_counter spike_window_counter_inst (
        .ep50trig       (ep50trig),
        .reset_sim      (reset_sim),
        .i_tick         (tick),
        .i_clear        (run_start),
        .i_spikes       (o_spikes),
        .o_window_count (window_count),
        .o_window_done  (o_window_done)
    );

endmodule

// ==== verification/motor_pool_tb.sv ====
`timescale 1ns/1ps

module motor_pool_tb;
    import motor_pool_pkg::*;

    localparam int APB_TIMEOUT = 8;

    // dut pins
    logic                 ep50trig;
    logic                 reset_sim;
    logic                 i_psel;
    logic                 i_penable;
    logic                 i_pwrite;
    addr_t                i_paddr;
    data_t                i_pwdata;
    data_t                o_prdata;
    logic                 o_pready;
    logic                 o_pslverr;
    logic [POOL_SIZE-1:0] o_spikes;
    logic                 o_window_done;

    // bookkeeping
    int          errors;
    int          checks;
    int          tests_run;
    int          test_errors_start;
    logic [31:0] rng_state;
    // phase flags seen by the concurrent checks
    logic        expect_silent;
    logic        expect_stopped;

    motor_pool_top motor_pool_top_inst (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .o_spikes      (o_spikes),
        .o_window_done (o_window_done)
    );

    // 100 ns clock
    initial
    begin
        ep50trig = 1'b0;
        forever #50 ep50trig = ~ep50trig;
    end

    ////////////////////////////////////////
    // concurrent checks
    ////////////////////////////////////////

    // zero wait states, ready in every access phase
    a_pready_in_access: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        (i_psel && i_penable) |-> o_pready
    ) else
    begin
        $display("FAIL t=%0t o_pready expected 1 got %0b", $time, o_pready);
        errors++;
    end

    a_pslverr_only_in_access: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        o_pslverr |-> (i_psel && i_penable)
    ) else
    begin
        $display("FAIL t=%0t o_pslverr outside an access phase", $time);
        errors++;
    end

    // zero gain, no spike anywhere
    a_silent_pool: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        !expect_silent || (o_spikes == '0)
    ) else
    begin
        $display("FAIL t=%0t o_spikes expected 0 got %b", $time, o_spikes);
        errors++;
    end

    // run off, windows must stop
    a_no_done_when_stopped: assert property (
        @(posedge ep50trig) disable iff (reset_sim)
        !expect_stopped || !o_window_done
    ) else
    begin
        $display("FAIL t=%0t o_window_done expected 0 got %0b", $time, o_window_done);
        errors++;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // no leak, so neuron k has fired floor(n*d_k/thresh) times after n ticks
    function automatic longint model_window_total(input int m, input longint gain,
                                                  input longint thresh);
        longint total;
        longint d;
        total = 0;
        for (int k = 0; k < POOL_SIZE; k++)
        begin
            d     = gain * (k + 1);
            total = total + (m * WINDOW_TICKS * d) / thresh
                          - ((m - 1) * WINDOW_TICKS * d) / thresh;
        end
        return total;
    endfunction

    task automatic expect_equal(input string name, input data_t expected, input data_t actual);
        checks++;
        assert (actual === expected) else
        begin
            $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at t=%0t: %s", $time, what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // setup then access, entered 1 ns after a rising edge
    task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic slverr);
        int waited;
        waited    = 0;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(posedge ep50trig);
        #1;
        i_penable = 1'b1;
        @(negedge ep50trig);
        while (!o_pready && waited < APB_TIMEOUT)
        begin
            @(negedge ep50trig);
            waited++;
        end
        if (!o_pready)
            abort_on_timeout("APB access never saw o_pready");
        rdata  = o_prdata;
        slverr = o_pslverr;
        @(posedge ep50trig);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic write_reg(input addr_t addr, input data_t wdata);
        data_t rdata;
        logic  slverr;
        apb_transfer(1'b1, addr, wdata, rdata, slverr);
        expect_equal("o_pslverr", 32'd0, data_t'(slverr));
    endtask

    task automatic read_reg(input addr_t addr, output data_t rdata);
        logic slverr;
        apb_transfer(1'b0, addr, 32'd0, rdata, slverr);
        expect_equal("o_pslverr", 32'd0, data_t'(slverr));
    endtask

    task automatic read_and_compare(input string name, input addr_t addr, input data_t expected);
        data_t rdata;
        read_reg(addr, rdata);
        expect_equal(name, expected, rdata);
    endtask

    task automatic wait_window_done(input int max_cycles);
        int n;
        n = 0;
        do
        begin
            @(posedge ep50trig);
            #1;
            n++;
        end
        while (!o_window_done && n < max_cycles);
        if (!o_window_done)
            abort_on_timeout("o_window_done never rose");
    endtask

    task automatic report_test(input int num, input string name);
        tests_run++;
        if (errors == test_errors_start)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - test_errors_start);
        test_errors_start = errors;
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial
    begin
        data_t rdata;
        logic  slverr;
        data_t per_val;
        data_t gain_val;
        data_t thresh_val;
        int    window_cycles;

        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        test_errors_start = 0;
        rng_state         = 32'd85;
        expect_silent     = 1'b0;
        expect_stopped    = 1'b0;
        reset_sim         = 1'b1;
        i_psel            = 1'b0;
        i_penable         = 1'b0;
        i_pwrite          = 1'b0;
        i_paddr           = '0;
        i_pwdata          = '0;
        repeat (10) @(posedge ep50trig);
        #1;
        reset_sim = 1'b0;

        // defaults after reset
        read_and_compare("CTRL", ADDR_CTRL, 32'd0);
        read_and_compare("PERIOD", ADDR_PERIOD, 32'd9);
        read_and_compare("GAIN", ADDR_GAIN, 32'd0);
        read_and_compare("THRESH", ADDR_THRESH, 32'd1000);
        read_and_compare("COUNT", ADDR_COUNT, 32'd0);
        report_test(1, "reset defaults");

        // random readback, then bad accesses must not disturb anything
        rng_state  = xorshift(rng_state);
        per_val    = rng_state & 32'h0000_FFFF;
        rng_state  = xorshift(rng_state);
        gain_val   = rng_state & 32'h00FF_FFFF;
        rng_state  = xorshift(rng_state);
        thresh_val = rng_state & 32'h00FF_FFFF;
        write_reg(ADDR_PERIOD, per_val);
        write_reg(ADDR_GAIN, gain_val);
        write_reg(ADDR_THRESH, thresh_val);
        read_and_compare("PERIOD", ADDR_PERIOD, per_val);
        read_and_compare("GAIN", ADDR_GAIN, gain_val);
        read_and_compare("THRESH", ADDR_THRESH, thresh_val);
        apb_transfer(1'b0, 8'h20, 32'd0, rdata, slverr);
        expect_equal("o_pslverr", 32'd1, data_t'(slverr));
        apb_transfer(1'b1, ADDR_COUNT, 32'h0000_5A5A, rdata, slverr);
        expect_equal("o_pslverr", 32'd1, data_t'(slverr));
        read_and_compare("CTRL", ADDR_CTRL, 32'd0);
        read_and_compare("PERIOD", ADDR_PERIOD, per_val);
        read_and_compare("GAIN", ADDR_GAIN, gain_val);
        read_and_compare("THRESH", ADDR_THRESH, thresh_val);
        read_and_compare("COUNT", ADDR_COUNT, 32'd0);
        report_test(2, "register readback and errors");

        // zero gain keeps the pool quiet
        per_val       = 32'd9;
        window_cycles = WINDOW_TICKS * (int'(per_val) + 1) + 20;
        write_reg(ADDR_PERIOD, per_val);
        write_reg(ADDR_GAIN, 32'd0);
        write_reg(ADDR_THRESH, 32'd1000);
        write_reg(ADDR_CTRL, 32'd1);
        expect_silent = 1'b1;
        repeat (2)
        begin
            wait_window_done(window_cycles);
            read_and_compare("COUNT", ADDR_COUNT, 32'd0);
        end
        write_reg(ADDR_CTRL, 32'd0);
        expect_silent = 1'b0;
        report_test(3, "zero gain");

        // random drive, three back to back windows
        rng_state     = xorshift(rng_state);
        thresh_val    = 32'd200 + (rng_state % 32'd50000);
        rng_state     = xorshift(rng_state);
        gain_val      = 32'd1 + (rng_state % (thresh_val / 32'd4 - 32'd1));
        rng_state     = xorshift(rng_state);
        per_val       = 32'd2 + (rng_state % 32'd8);
        window_cycles = WINDOW_TICKS * (int'(per_val) + 1) + 20;
        write_reg(ADDR_THRESH, thresh_val);
        write_reg(ADDR_GAIN, gain_val);
        write_reg(ADDR_PERIOD, per_val);
        write_reg(ADDR_CTRL, 32'd1);
        for (int m = 1; m <= 3; m++)
        begin
            wait_window_done(window_cycles);
            read_and_compare("COUNT", ADDR_COUNT,
                data_t'(model_window_total(m, longint'(gain_val), longint'(thresh_val))));
        end
        report_test(4, "random drive windows");

        // stop, hold off, restart from zero potentials
        write_reg(ADDR_CTRL, 32'd0);
        expect_stopped = 1'b1;
        repeat (3 * window_cycles) @(posedge ep50trig);
        #1;
        expect_stopped = 1'b0;
        // last total survives the pause
        read_and_compare("COUNT", ADDR_COUNT,
            data_t'(model_window_total(3, longint'(gain_val), longint'(thresh_val))));
        write_reg(ADDR_CTRL, 32'd1);
        wait_window_done(window_cycles);
        read_and_compare("COUNT", ADDR_COUNT,
            data_t'(model_window_total(1, longint'(gain_val), longint'(thresh_val))));
        write_reg(ADDR_CTRL, 32'd0);
        report_test(5, "stop and restart");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== motor_pool.f ====
design/motor_pool_pkg.sv
design/apb_param_bank.sv
design/afferent_drive.sv
design/lif_neuron.sv
design/spike_window_counter.sv
design/motor_pool_top.sv
verification/motor_pool_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = motor_pool_tb
FILELIST  = motor_pool.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
